// ==== cache_pkg.sv ====
// Cache geometry constants
package cache_pkg;

    // Address and data widths
    localparam int ADDR_W   = 32;  // Byte address
    localparam int DATA_W   = 64;  // CPU word and memory beat
    localparam int STRB_W   = 8;   // One strobe per byte of a beat
    localparam int LINE_W   = 128; // SRAM row, two beats side by side

    // Organization
    localparam int WAYS     = 4;   // Associativity
    localparam int WAY_W    = 2;   // Way select
    localparam int INDEX_W  = 4;   // 16 sets
    localparam int OFFSET_W = 6;   // 64-byte block
    localparam int TAG_W    = 22;  // Address bits 31..10

    // Block transfer
    localparam int BEATS    = 8;   // 64-bit beats per block

endpackage

// ==== sram_macro.sv ====
// Single-port SRAM model
module sram_macro
#(
    parameter int DEPTH = 64,  // Rows
    parameter int WIDTH = 128  // Bits per row
)
(
    input  logic             clk,
    input  logic             cen,  // Chip enable, active high
    input  logic             wen,  // Write enable, active high
    input  logic [WIDTH-1:0] bwen, // Per-bit write enable
    input  logic [5:0]       a,    // Row address
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] mem [0:DEPTH-1]; // Storage array

    always_ff @(posedge clk)
    begin
        if (cen && wen)
            mem[a] <= (mem[a] & ~bwen) | (d & bwen); // Merge enabled bits only
        else if (cen)
            q <= mem[a];                             // Registered read, holds otherwise
    end

endmodule

// ==== cache_sram.sv ====
// Cache data array
module cache_sram
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [WAY_W-1:0]    way,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,
    input  logic                sram_r_en,
    input  logic                sram_w_en,
    input  logic [DATA_W-1:0]   sram_w_data,
    input  logic [STRB_W-1:0]   sram_w_strb,
    output logic [DATA_W-1:0]   sram_r_data
);

    localparam int BANKS = 4; // One macro per 16-byte quarter of a block

    logic                cen;                 // Shared by all banks
    logic [DATA_W-1:0]   strb_bits;           // Byte strobes widened to bits
    logic [LINE_W-1:0]   bwen;                // Bit enables for the chosen half
    logic [LINE_W-1:0]   bank_q [0:BANKS-1];  // Raw macro outputs
    logic [LINE_W-1:0]   bank_sel;            // Row picked by registered offset
    logic [OFFSET_W-1:0] offset_r;            // Offset of the last read

    assign cen = sram_r_en || sram_w_en;

    always_comb
    begin
        strb_bits = '0;
        for (int b = 0; b < STRB_W; b++)
            strb_bits[b*8 +: 8] = {8{sram_w_strb[b]}};
    end

    // Offset bit 3 picks the upper or lower beat of the row
    assign bwen = offset[3] ? {strb_bits, {DATA_W{1'b0}}} : {{DATA_W{1'b0}}, strb_bits};

    for (genvar g = 0; g < BANKS; g++)
    begin : bank
        sram_macro #(
            .DEPTH (64),
            .WIDTH (LINE_W)
        ) sram_i (
            .clk  (clk),
            .cen  (cen),
            .wen  (sram_w_en && (offset[5:4] == 2'(g))), // Only the addressed bank writes
            .bwen (bwen),
            .a    ({way, index}),                        // Way-major row address
            .d    ({2{sram_w_data}}),                    // Beat copied to both halves
            .q    (bank_q[g])
        );
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            offset_r <= '0;
        else if (sram_r_en)
            offset_r <= offset; // Follows the read, stable while data is held
    end

    assign bank_sel    = bank_q[offset_r[5:4]];
    assign sram_r_data = offset_r[3] ? bank_sel[LINE_W-1:DATA_W] : bank_sel[DATA_W-1:0];

endmodule

// ==== cache_tag.sv ====
// Tag, valid and dirty store
module cache_tag
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index,
    input  logic [TAG_W-1:0]   cmp_tag,
    input  logic               tag_we,       // Write tag, set valid
    input  logic [WAY_W-1:0]   tag_way,
    input  logic               tag_dirty,    // Dirty value on write
    input  logic [WAY_W-1:0]   victim_way,
    output logic               hit,
    output logic [WAY_W-1:0]   hit_way,
    output logic [WAYS-1:0]    valid_bits,   // Selected set
    output logic [TAG_W-1:0]   victim_tag,
    output logic               victim_dirty
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem   [0:SETS-1][0:WAYS-1]; // Stored address bits 31..10
    logic [WAYS-1:0]  valid_mem [0:SETS-1];
    logic [WAYS-1:0]  dirty_mem [0:SETS-1];

    // Valid and dirty cleared at reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end
        else if (tag_we)
        begin
            valid_mem[index][tag_way] <= 1'b1;
            dirty_mem[index][tag_way] <= tag_dirty; // Set on write hit, clear on refill
        end
    end

    always_ff @(posedge clk)
    begin
        if (tag_we)
            tag_mem[index][tag_way] <= cmp_tag; // Same tag rewritten on a write hit
    end

    // Parallel compare across the set
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (valid_mem[index][w] && (tag_mem[index][w] == cmp_tag))
            begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign valid_bits   = valid_mem[index];
    assign victim_tag   = tag_mem[index][victim_way];   // Write-back address source
    assign victim_dirty = dirty_mem[index][victim_way];

endmodule

// ==== cache_ctrl.sv ====
// Cache controller
module cache_ctrl
    import cache_pkg::*;
#(
    parameter logic [7:0] LFSR_SEED = 8'h01 // Nonzero
)
(
    input  logic                clk,
    input  logic                rst,
    // CPU side
    input  logic                cpu_req,
    input  logic                cpu_we,
    input  logic [ADDR_W-1:0]   cpu_addr,
    input  logic [DATA_W-1:0]   cpu_w_data,
    input  logic [STRB_W-1:0]   cpu_w_strb,
    output logic                cpu_busy,
    output logic                cpu_ready,
    output logic [DATA_W-1:0]   cpu_r_data,
    // Memory side
    output logic                mem_req,
    output logic                mem_we,
    output logic [ADDR_W-1:0]   mem_addr,
    output logic [DATA_W-1:0]   mem_w_data,
    input  logic                mem_ack,
    input  logic [DATA_W-1:0]   mem_r_data,
    // Data array
    output logic [WAY_W-1:0]    way,
    output logic [INDEX_W-1:0]  index,
    output logic [OFFSET_W-1:0] offset,
    output logic                sram_r_en,
    output logic                sram_w_en,
    output logic [DATA_W-1:0]   sram_w_data,
    output logic [STRB_W-1:0]   sram_w_strb,
    input  logic [DATA_W-1:0]   sram_r_data,
    // Tag store
    output logic [TAG_W-1:0]    cmp_tag,
    output logic                tag_we,
    output logic [WAY_W-1:0]    tag_way,
    output logic                tag_dirty,
    output logic [WAY_W-1:0]    victim_way,
    input  logic                hit,
    input  logic [WAY_W-1:0]    hit_way,
    input  logic [WAYS-1:0]     valid_bits,
    input  logic [TAG_W-1:0]    victim_tag,
    input  logic                victim_dirty
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOOKUP  = 3'd1; // Tag compare and SRAM access on hit
    localparam logic [2:0] S_WB_READ = 3'd2; // Read one victim beat
    localparam logic [2:0] S_WB_SEND = 3'd3; // Hold beat until memory ack
    localparam logic [2:0] S_REFILL  = 3'd4; // Fetch and write one beat per ack
    localparam logic [2:0] S_RESPOND = 3'd5; // Ready pulse with read data valid

    logic [2:0]          state;
    logic [2:0]          beat_r;      // Beat within the block
    logic                gap_r;       // Forces req low after each memory ack
    logic [7:0]          lfsr_r;
    logic                accept;      // Request taken this cycle
    logic                last_beat;
    logic                fill_we;     // Refill beat lands in the array
    logic [WAY_W-1:0]    pick_way;    // Replacement choice
    // Registered request
    logic                we_r;
    logic [TAG_W-1:0]    tag_r;
    logic [INDEX_W-1:0]  index_r;
    logic [OFFSET_W-1:0] off_r;
    logic [DATA_W-1:0]   wdata_r;
    logic [STRB_W-1:0]   strb_r;
    // Victim captured on a miss
    logic [WAY_W-1:0]    vict_way_r;
    logic [TAG_W-1:0]    vict_tag_r;

    assign accept    = cpu_req && ((state == S_IDLE) || (state == S_RESPOND));
    assign last_beat = (beat_r == 3'(BEATS - 1));
    assign fill_we   = (state == S_REFILL) && mem_ack;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            we_r    <= cpu_we;
            tag_r   <= cpu_addr[ADDR_W-1 -: TAG_W];
            index_r <= cpu_addr[OFFSET_W +: INDEX_W];
            off_r   <= cpu_addr[OFFSET_W-1:0];
            wdata_r <= cpu_w_data;
            strb_r  <= cpu_w_strb;
        end
    end

    // Fibonacci LFSR with taps 8 6 5 4 stepping every cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            lfsr_r <= LFSR_SEED;
        else
            lfsr_r <= {lfsr_r[6:0], lfsr_r[7] ^ lfsr_r[5] ^ lfsr_r[4] ^ lfsr_r[3]};
    end

    // Lowest invalid way first and random only when the set is full
    always_comb
    begin
        pick_way = lfsr_r[1:0];
        for (int w = WAYS - 1; w >= 0; w--)
            if (!valid_bits[w])
                pick_way = WAY_W'(w);
    end

    always_ff @(posedge clk)
    begin
        if ((state == S_LOOKUP) && !hit)
        begin
            vict_way_r <= pick_way;
            vict_tag_r <= victim_tag; // Old block address for write-back
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= S_IDLE;
            beat_r <= '0;
            gap_r  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (cpu_req)
                        state <= S_LOOKUP;
                S_LOOKUP:
                begin
                    beat_r <= '0;
                    gap_r  <= 1'b0;
                    if (hit)
                        state <= S_RESPOND;
                    else if (victim_dirty)
                        state <= S_WB_READ;  // Write back before refill
                    else
                        state <= S_REFILL;
                end
                S_WB_READ:
                    state <= S_WB_SEND;      // Data arrives next cycle
                S_WB_SEND:
                    if (mem_ack)
                    begin
                        beat_r <= beat_r + 3'd1; // Wraps to 0 for refill
                        gap_r  <= 1'b1;          // Req low for a cycle before the next beat
                        state  <= last_beat ? S_REFILL : S_WB_READ;
                    end
                S_REFILL:
                begin
                    gap_r <= mem_ack;
                    if (mem_ack)
                    begin
                        beat_r <= beat_r + 3'd1;
                        if (last_beat)
                            state <= S_LOOKUP; // Replay as a hit
                    end
                end
                S_RESPOND:
                    state <= cpu_req ? S_LOOKUP : S_IDLE; // Back-to-back allowed
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // CPU outputs
    assign cpu_busy   = (state != S_IDLE) && (state != S_RESPOND);
    assign cpu_ready  = (state == S_RESPOND);
    assign cpu_r_data = sram_r_data;

    // Beat address is block base plus beat times 8
    assign mem_req    = (state == S_WB_SEND) || ((state == S_REFILL) && !gap_r);
    assign mem_we     = (state == S_WB_SEND);
    assign mem_addr   = (state == S_WB_SEND) ? {vict_tag_r, index_r, beat_r, 3'b000}
                                             : {tag_r, index_r, beat_r, 3'b000};
    assign mem_w_data = sram_r_data; // Held by the SRAM while idle

    // Data array controls
    assign way         = (state == S_LOOKUP) ? hit_way : vict_way_r;
    assign index       = index_r;
    assign offset      = (state == S_LOOKUP) ? off_r : {beat_r, 3'b000};
    assign sram_r_en   = ((state == S_LOOKUP) && hit && !we_r) || (state == S_WB_READ);
    assign sram_w_en   = ((state == S_LOOKUP) && hit && we_r) || fill_we;
    assign sram_w_data = (state == S_REFILL) ? mem_r_data : wdata_r;
    assign sram_w_strb = (state == S_REFILL) ? '1 : strb_r; // Refill writes whole beats

    // Tag store controls
    assign cmp_tag    = tag_r;
    assign tag_we     = ((state == S_LOOKUP) && hit && we_r) || (fill_we && last_beat);
    assign tag_way    = (state == S_LOOKUP) ? hit_way : vict_way_r;
    assign tag_dirty  = (state == S_LOOKUP); // Dirty on write hit and clean after refill
    assign victim_way = pick_way;

endmodule

// ==== cache_top.sv ====
// Data cache top level
module cache_top
    import cache_pkg::*;
#(
    parameter logic [7:0] LFSR_SEED = 8'h01
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_w_data,
    input  logic [STRB_W-1:0] cpu_w_strb,
    output logic              cpu_busy,
    output logic              cpu_ready,
    output logic [DATA_W-1:0] cpu_r_data,
    output logic              mem_req,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_w_data,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_r_data
);

    logic [WAY_W-1:0]    way;          // Data array way
    logic [INDEX_W-1:0]  index;        // Shared by array and tag store
    logic [OFFSET_W-1:0] offset;
    logic                sram_r_en;
    logic                sram_w_en;
    logic [DATA_W-1:0]   sram_w_data;
    logic [STRB_W-1:0]   sram_w_strb;
    logic [DATA_W-1:0]   sram_r_data;
    logic [TAG_W-1:0]    cmp_tag;
    logic                tag_we;
    logic [WAY_W-1:0]    tag_way;
    logic                tag_dirty;
    logic [WAY_W-1:0]    victim_way;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAYS-1:0]     valid_bits;
    logic [TAG_W-1:0]    victim_tag;
    logic                victim_dirty;

    cache_ctrl #(.LFSR_SEED (LFSR_SEED)) ctrl_i (.*); // Names match one to one

    cache_tag tag_i (.*);

    cache_sram sram_i (.*);

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset
module tb_clock
(
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    logic clk_r = 1'b0; // Starts low, no edge at time zero
    logic rst_r = 1'b1; // Reset from the first edge on

    assign clk = clk_r;
    assign rst = rst_r;

    always #2 clk_r = ~clk_r; // 4 ns period

    initial
    begin
        repeat (4) @(posedge clk_r);
        rst_r <= 1'b0;        // Released after 4 cycles
    end

endmodule

// ==== tb_mem.sv ====
// Main memory model
module tb_mem
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_w_data,
    output logic              mem_ack,
    output logic [DATA_W-1:0] mem_r_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_W-1:0] beats [int unsigned]; // Written beats, keyed by beat address
    logic              ack_r    = 1'b0;
    logic [DATA_W-1:0] data_r   = '0;
    logic              active   = 1'b0;      // Beat accepted, ack pending
    int unsigned       wait_cnt = 0;
    int unsigned       seed     = 89;

    assign mem_ack    = ack_r;
    assign mem_r_data = data_r;

    // LCG, halves swapped so the low bits are usable
    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Untouched words read as word address XOR 5A5A5A5A
    function automatic logic [DATA_W-1:0] fetch_beat(logic [ADDR_W-1:0] addr);
        logic [31:0] word;
        word = addr >> 2;
        if (beats.exists(addr >> 3))
            return beats[addr >> 3];
        return {(word + 32'd1) ^ 32'h5A5A_5A5A, word ^ 32'h5A5A_5A5A};
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            ack_r  <= 1'b0;
            active <= 1'b0;
        end
        else
        begin
            ack_r <= 1'b0;                          // One-cycle pulse
            if (active)
            begin
                if (wait_cnt == 0)
                begin
                    ack_r  <= 1'b1;
                    active <= 1'b0;
                    if (mem_we)
                        beats[mem_addr >> 3] = mem_w_data; // Write-back beat
                    else
                        data_r <= fetch_beat(mem_addr);    // Valid with ack
                end
                else
                    wait_cnt <= wait_cnt - 1;
            end
            else if (mem_req && !ack_r)             // Req still high on the ack cycle
            begin
                active   <= 1'b1;
                wait_cnt <= next_rand() % 4;        // Ack 1 to 4 cycles later
            end
        end
    end

endmodule

// ==== tb_checker.sv ====
// CPU response checker
module tb_checker
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_w_data,
    input  logic [STRB_W-1:0] cpu_w_strb,
    input  logic              cpu_busy,
    input  logic              cpu_ready,
    input  logic [DATA_W-1:0] cpu_r_data,
    input  logic              mem_req,
    input  logic              mem_ack,
    input  int                entry_id,
    input  logic [DATA_W-1:0] exp_data,
    input  logic              exp_known,  // Table gives a value of its own
    input  logic              exp_hit,    // 2-cycle latency required
    output int                errors,
    output int                checked
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]        gold [int unsigned]; // Golden bytes written so far
    logic              started   = 1'b0;    // First request seen
    logic              pending   = 1'b0;
    logic              reset_bad = 1'b0;
    logic              ack_seen  = 1'b0;    // Memory ack in the previous cycle
    int                lat       = 0;       // Cycles since the request
    int                err_cnt   = 0;
    int                done_cnt  = 0;
    int                id_c;                // Captured request
    logic              we_c;
    logic [ADDR_W-1:0] addr_c;
    logic [DATA_W-1:0] wdata_c;
    logic [STRB_W-1:0] strb_c;
    logic [DATA_W-1:0] exp_c;
    logic              known_c;
    logic              hit_c;

    assign errors  = err_cnt;
    assign checked = done_cnt;

    // Written byte if any or else the byte of word (a >> 2) XOR 5A5A5A5A
    function automatic logic [DATA_W-1:0] golden_beat(logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] beat;
        logic [31:0]       word;
        logic [ADDR_W-1:0] a;
        for (int i = 0; i < STRB_W; i++)
        begin
            a    = {addr[ADDR_W-1:3], 3'(i)};
            word = (a >> 2) ^ 32'h5A5A_5A5A;
            if (gold.exists(a))
                beat[i*8 +: 8] = gold[a];
            else
                beat[i*8 +: 8] = word[a[1:0]*8 +: 8];
        end
        return beat;
    endfunction

    // Sampled at negedge where all DUT outputs have settled
    always @(negedge clk)
    begin
        logic [DATA_W-1:0] want;
        logic              bad;
        if (!started && !reset_bad && ((cpu_ready !== 1'b0) || (cpu_busy !== 1'b0)
                                       || (mem_req !== 1'b0)))
        begin
            reset_bad = 1'b1;
            err_cnt  += 1;
            $display("Cache outputs were active during reset or before the first request");
        end
        if (ack_seen && (mem_req !== 1'b0))
        begin
            err_cnt += 1;
            $display("mem_req did not drop for a cycle after a memory acknowledge");
        end
        ack_seen = mem_ack;
        if (pending)
            lat += 1;
        if (pending && (cpu_busy !== !cpu_ready))
        begin
            err_cnt += 1;
            $display("[FAIL] entry %0d cpu_busy expected %h got %h",
                     id_c, !cpu_ready, cpu_busy);
        end
        if (pending && cpu_ready)
        begin
            pending   = 1'b0;
            done_cnt += 1;
            want      = golden_beat(addr_c);
            if (known_c && (cpu_r_data != exp_c))
                want = exp_c;                      // Report the table value
            bad       = !we_c && (cpu_r_data != want);
            if (bad)
            begin
                err_cnt += 1;
                $display("[FAIL] entry %0d cpu_r_data expected %h got %h",
                         id_c, want, cpu_r_data);
            end
            else if (hit_c && (lat != 2))
            begin
                err_cnt += 1;
                $display("Entry %0d took %0d cycles although a 2-cycle hit was expected",
                         id_c, lat);
            end
            else
                $display("entry %0d %s addr %h ok in %0d cycles",
                         id_c, we_c ? "wr" : "rd", addr_c, lat);
            if (we_c)
                for (int i = 0; i < STRB_W; i++)
                    if (strb_c[i])
                        gold[{addr_c[ADDR_W-1:3], 3'(i)}] = wdata_c[i*8 +: 8]; // Merge
        end
        else if (!rst && started && !pending && cpu_ready)
        begin
            err_cnt += 1;
            $display("cpu_ready pulsed with no request outstanding");
        end
        if (cpu_req)
        begin
            if (pending || cpu_busy)
            begin
                err_cnt += 1;
                $display("Request for entry %0d was raised while the cache was busy", entry_id);
            end
            started = 1'b1;
            pending = 1'b1;
            lat     = 0;
            id_c    = entry_id;
            we_c    = cpu_we;
            addr_c  = cpu_addr;
            wdata_c = cpu_w_data;
            strb_c  = cpu_w_strb;
            exp_c   = exp_data;
            known_c = exp_known;
            hit_c   = exp_hit;
        end
    end

endmodule

// ==== cache_tb.sv ====
// Data cache testbench
module cache_tb
    import cache_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst;
    logic              cpu_req;
    logic              cpu_we;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_w_data;
    logic [STRB_W-1:0] cpu_w_strb;
    logic              cpu_busy;
    logic              cpu_ready;
    logic [DATA_W-1:0] cpu_r_data;
    logic              mem_req;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_w_data;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_r_data;
    int                entry_id;
    logic [DATA_W-1:0] exp_data;
    logic              exp_known;
    logic              exp_hit;
    int                errors;
    int                checked;

    // Stimulus table, one element per entry in each queue
    logic              op_q    [$]; // 1 for a write
    logic [ADDR_W-1:0] addr_q  [$];
    logic [DATA_W-1:0] data_q  [$];
    logic [STRB_W-1:0] strb_q  [$];
    logic [DATA_W-1:0] exp_q   [$];
    logic              known_q [$];
    logic              hit_q   [$];

    int                cycles = 0;
    int                limit  = 1000000; // Replaced once the table is built
    int unsigned       seed   = 89;

    tb_clock clk_gen_i (.clk (clk), .rst (rst));

    cache_top #(.LFSR_SEED (8'hA7)) dut_i (.*);

    tb_mem mem_i (.*);

    tb_checker chk_i (.*);

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Memory contents before any write
    function automatic logic [DATA_W-1:0] init_beat(logic [ADDR_W-1:0] addr);
        logic [31:0] word;
        word = addr >> 2;
        return {(word + 32'd1) ^ 32'h5A5A_5A5A, word ^ 32'h5A5A_5A5A};
    endfunction

    function automatic logic [DATA_W-1:0] merge_beat(logic [DATA_W-1:0] old_d,
                                                     logic [DATA_W-1:0] new_d,
                                                     logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        for (int i = 0; i < STRB_W; i++)
            res[i*8 +: 8] = strb[i] ? new_d[i*8 +: 8] : old_d[i*8 +: 8];
        return res;
    endfunction

    task automatic add_entry(logic we, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                             logic [STRB_W-1:0] strb, logic [DATA_W-1:0] exp,
                             logic known, logic hit);
        op_q.push_back(we);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        exp_q.push_back(exp);
        known_q.push_back(known);
        hit_q.push_back(hit);
    endtask

    task automatic build_table();
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] e;
        int unsigned       r;
        int                j;
        a = 32'h0000_1000;                                      // Tag 4, set 0
        add_entry(1'b0, a, '0, '0, init_beat(a), 1'b1, 1'b0);   // First read after reset
        add_entry(1'b0, a, '0, '0, init_beat(a), 1'b1, 1'b1);   // Immediate repeat hits
        d = 64'hDEAD_BEEF_0BAD_F00D;
        add_entry(1'b1, a, d, 8'hFF, '0, 1'b0, 1'b1);
        add_entry(1'b0, a, '0, '0, d, 1'b1, 1'b1);
        a = 32'h0000_2048;                                      // Set 1, offset 8
        d = 64'h1122_3344_5566_7788;
        e = merge_beat(init_beat(a), d, 8'hA5);
        add_entry(1'b1, a, d, 8'hA5, '0, 1'b0, 1'b0);           // Partial write miss
        add_entry(1'b0, a, '0, '0, e, 1'b1, 1'b1);
        d = 64'hFFEE_DDCC_BBAA_9988;
        add_entry(1'b1, a, d, 8'h0F, '0, 1'b0, 1'b1);
        add_entry(1'b0, a, '0, '0, merge_beat(e, d, 8'h0F), 1'b1, 1'b1);
        for (int k = 1; k <= 6; k++)                            // Six blocks, set 2
        begin
            r = next_rand();
            a = (32'(k) << 10) | 32'h80 | (32'(k) << 3);
            add_entry(1'b1, a, {r, ~r}, 8'hFF, '0, 1'b0, 1'b0);
        end
        for (int k = 1; k <= 6; k++)
            add_entry(1'b0, (32'(k) << 10) | 32'h80 | (32'(k) << 3), '0, '0, '0, 1'b0, 1'b0);
        base = (32'h30 << 10) | 32'hC0;                         // Tag 30, set 3
        for (int b = 0; b < BEATS; b++)                         // Both halves of each bank
        begin
            r = next_rand();
            add_entry(1'b1, base + 32'(b * 8), {r, 32'(b)}, 8'hFF, '0, 1'b0, b != 0);
        end
        for (int k = 1; k <= 6; k++)                            // Push the block out
        begin
            r = next_rand();
            add_entry(1'b1, base + (32'(k) << 10), {~r, r}, 8'hFF, '0, 1'b0, 1'b0);
        end
        for (int b = 0; b < BEATS; b++)
            add_entry(1'b0, base + 32'(b * 8), '0, '0, '0, 1'b0, 1'b0);
        for (int n = 0; n < 120; n++)                           // 40 blocks over sets 8..15
        begin
            r = next_rand();
            j = r % 40;
            a = ((32'h40 + 32'(j / 8)) << 10) | (32'(8 + j % 8) << 6)
                | (32'(next_rand() % 8) << 3);
            r = next_rand();
            d = {next_rand(), next_rand()};
            if (r[4])
                add_entry(1'b1, a, d, r[15:8], '0, 1'b0, 1'b0);
            else
                add_entry(1'b0, a, '0, '0, '0, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_w_data = '0;
        cpu_w_strb = '0;
        entry_id   = 0;
        exp_data   = '0;
        exp_known  = 1'b0;
        exp_hit    = 1'b0;
        build_table();
        limit = addr_q.size() * 120 + 100;                      // Worst miss well inside
        wait (rst == 1'b0);
        repeat (3) @(posedge clk);                              // Idle after reset
        for (int i = 0; i < addr_q.size(); i++)
        begin
            cpu_req    <= 1'b1;
            cpu_we     <= op_q[i];
            cpu_addr   <= addr_q[i];
            cpu_w_data <= data_q[i];
            cpu_w_strb <= strb_q[i];
            entry_id   <= i;
            exp_data   <= exp_q[i];
            exp_known  <= known_q[i];
            exp_hit    <= hit_q[i];
            @(posedge clk);
            cpu_req    <= 1'b0;                                 // One-cycle pulse
            do
            begin
                @(posedge clk);
            end
            while (!cpu_ready);
        end
        @(posedge clk);
        $display("Entries checked %0d of %0d, errors %0d", checked, addr_q.size(), errors);
        if ((errors == 0) && (checked == addr_q.size()))
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles += 1;
        if (cycles > limit)
        begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
cache_pkg.sv
sram_macro.sv
cache_sram.sv
cache_tag.sv
cache_ctrl.sv
cache_top.sv
tb_clock.sv
tb_mem.sv
tb_checker.sv
cache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/100ps --top-module cache_tb -f verilog.f -o cache_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/cache_sim)
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
